// File: src/rs_pkg.sv
package rs_pkg;

    // word and tag sizes
    localparam int data_width   = 32;
    localparam int rob_id_width = 4;

    // tag 0 means the operand value is already present
    localparam logic [rob_id_width-1:0] zero_rob = '0;

    // station geometry, one spare index bit for "no entry"
    localparam int rs_size     = 16;
    localparam int rs_id_width = 5;
    localparam logic [rs_id_width-1:0] invalid_rs = 5'd16;

    localparam int op_width = 4;

    // decoded opcodes
    localparam logic [op_width-1:0] op_nop   = 4'd0;
    localparam logic [op_width-1:0] op_add   = 4'd1;
    localparam logic [op_width-1:0] op_sub   = 4'd2;
    localparam logic [op_width-1:0] op_and   = 4'd3;
    localparam logic [op_width-1:0] op_or    = 4'd4;
    localparam logic [op_width-1:0] op_xor   = 4'd5;
    localparam logic [op_width-1:0] op_sll   = 4'd6;
    localparam logic [op_width-1:0] op_srl   = 4'd7;
    localparam logic [op_width-1:0] op_sra   = 4'd8;
    localparam logic [op_width-1:0] op_slt   = 4'd9;
    localparam logic [op_width-1:0] op_sltu  = 4'd10;
    localparam logic [op_width-1:0] op_addi  = 4'd11;
    localparam logic [op_width-1:0] op_lui   = 4'd12;
    localparam logic [op_width-1:0] op_auipc = 4'd13;
    localparam logic [op_width-1:0] op_jal   = 4'd14;

endpackage

// File: src/res_station.sv
`timescale 1ns/1ps

module res_station (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rdy,
    input  logic                              rollback,

    input  logic                              ena,
    input  logic [rs_pkg::op_width-1:0]       op,
    input  logic [rs_pkg::data_width-1:0]     v1,
    input  logic [rs_pkg::data_width-1:0]     v2,
    input  logic [rs_pkg::rob_id_width-1:0]   q1,
    input  logic [rs_pkg::rob_id_width-1:0]   q2,
    input  logic [rs_pkg::data_width-1:0]     pc,
    input  logic [rs_pkg::data_width-1:0]     imm,
    input  logic [rs_pkg::rob_id_width-1:0]   rob_id,
    output logic                              full,

    output logic [rs_pkg::op_width-1:0]       issue_op,
    output logic [rs_pkg::data_width-1:0]     issue_v1,
    output logic [rs_pkg::data_width-1:0]     issue_v2,
    output logic [rs_pkg::data_width-1:0]     issue_pc,
    output logic [rs_pkg::data_width-1:0]     issue_imm,
    output logic [rs_pkg::rob_id_width-1:0]   issue_rob_id,

    input  logic                              alu_valid,
    input  logic [rs_pkg::rob_id_width-1:0]   alu_rob_id,
    input  logic [rs_pkg::data_width-1:0]     alu_result,
    input  logic                              ls_valid,
    input  logic [rs_pkg::rob_id_width-1:0]   ls_rob_id,
    input  logic [rs_pkg::data_width-1:0]     ls_result
);

    // entry storage
    logic                            busy   [rs_pkg::rs_size];
    logic [rs_pkg::op_width-1:0]     e_op   [rs_pkg::rs_size];
    logic [rs_pkg::data_width-1:0]   e_v1   [rs_pkg::rs_size];
    logic [rs_pkg::data_width-1:0]   e_v2   [rs_pkg::rs_size];
    logic [rs_pkg::rob_id_width-1:0] e_q1   [rs_pkg::rs_size];
    logic [rs_pkg::rob_id_width-1:0] e_q2   [rs_pkg::rs_size];
    logic [rs_pkg::data_width-1:0]   e_pc   [rs_pkg::rs_size];
    logic [rs_pkg::data_width-1:0]   e_imm  [rs_pkg::rs_size];
    logic [rs_pkg::rob_id_width-1:0] e_rob  [rs_pkg::rs_size];

    logic [rs_pkg::rs_id_width-1:0]  free_idx;
    logic [rs_pkg::rs_id_width-1:0]  exec_idx;

    // low bits address the array, the top bit only flags invalid_rs
    logic [rs_pkg::rs_id_width-2:0]  free_slot;
    logic [rs_pkg::rs_id_width-2:0]  exec_slot;

    // incoming operands after same-cycle forwarding
    logic [rs_pkg::rob_id_width-1:0] ins_q1;
    logic [rs_pkg::rob_id_width-1:0] ins_q2;
    logic [rs_pkg::data_width-1:0]   ins_v1;
    logic [rs_pkg::data_width-1:0]   ins_v2;

    // lowest free and lowest ready entries; scan downward so index 0 wins
    always_comb begin
        free_idx = rs_pkg::invalid_rs;
        exec_idx = rs_pkg::invalid_rs;
        for (int i = rs_pkg::rs_size - 1; i >= 0; i--) begin
            if (!busy[i]) begin
                free_idx = i[rs_pkg::rs_id_width-1:0];
            end
            if (busy[i] && e_q1[i] == rs_pkg::zero_rob && e_q2[i] == rs_pkg::zero_rob) begin
                exec_idx = i[rs_pkg::rs_id_width-1:0];
            end
        end
    end

    assign free_slot = free_idx[rs_pkg::rs_id_width-2:0];
    assign exec_slot = exec_idx[rs_pkg::rs_id_width-2:0];
    assign full      = (free_idx == rs_pkg::invalid_rs);

    // alu bus takes priority, though both never carry the same tag
    always_comb begin
        ins_q1 = q1;
        ins_v1 = v1;
        if (q1 != rs_pkg::zero_rob && alu_valid && q1 == alu_rob_id) begin
            ins_q1 = rs_pkg::zero_rob;
            ins_v1 = alu_result;
        end else if (q1 != rs_pkg::zero_rob && ls_valid && q1 == ls_rob_id) begin
            ins_q1 = rs_pkg::zero_rob;
            ins_v1 = ls_result;
        end

        ins_q2 = q2;
        ins_v2 = v2;
        if (q2 != rs_pkg::zero_rob && alu_valid && q2 == alu_rob_id) begin
            ins_q2 = rs_pkg::zero_rob;
            ins_v2 = alu_result;
        end else if (q2 != rs_pkg::zero_rob && ls_valid && q2 == ls_rob_id) begin
            ins_q2 = rs_pkg::zero_rob;
            ins_v2 = ls_result;
        end
    end

    // control state
    always_ff @(posedge clk) begin
        if (rst || rollback) begin
            for (int i = 0; i < rs_pkg::rs_size; i++) begin
                busy[i] <= 1'b0;
            end
            issue_op <= rs_pkg::op_nop;
        end else if (rdy) begin
            if (exec_idx == rs_pkg::invalid_rs) begin
                issue_op <= rs_pkg::op_nop;
            end else begin
                busy[exec_slot] <= 1'b0;
                issue_op        <= e_op[exec_slot];
            end
            if (ena && !full) begin
                busy[free_slot] <= 1'b1;
            end
        end
    end

    // issue payload and entry payload
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (exec_idx != rs_pkg::invalid_rs) begin
                issue_v1     <= e_v1[exec_slot];
                issue_v2     <= e_v2[exec_slot];
                issue_pc     <= e_pc[exec_slot];
                issue_imm    <= e_imm[exec_slot];
                issue_rob_id <= e_rob[exec_slot];
            end

            // wakeup from both result buses
            for (int i = 0; i < rs_pkg::rs_size; i++) begin
                if (busy[i] && alu_valid && e_q1[i] == alu_rob_id) begin
                    e_v1[i] <= alu_result;
                    e_q1[i] <= rs_pkg::zero_rob;
                end else if (busy[i] && ls_valid && e_q1[i] == ls_rob_id) begin
                    e_v1[i] <= ls_result;
                    e_q1[i] <= rs_pkg::zero_rob;
                end
                if (busy[i] && alu_valid && e_q2[i] == alu_rob_id) begin
                    e_v2[i] <= alu_result;
                    e_q2[i] <= rs_pkg::zero_rob;
                end else if (busy[i] && ls_valid && e_q2[i] == ls_rob_id) begin
                    e_v2[i] <= ls_result;
                    e_q2[i] <= rs_pkg::zero_rob;
                end
            end

            if (ena && !full) begin
                e_op[free_slot]  <= op;
                e_v1[free_slot]  <= ins_v1;
                e_v2[free_slot]  <= ins_v2;
                e_q1[free_slot]  <= ins_q1;
                e_q2[free_slot]  <= ins_q2;
                e_pc[free_slot]  <= pc;
                e_imm[free_slot] <= imm;
                e_rob[free_slot] <= rob_id;
            end
        end
    end

    // dispatcher must respect full
    a_no_insert_when_full: assert property (
        @(posedge clk) disable iff (rst) (ena && rdy && !rollback) |-> !full
    ) else $error("dispatch strobe while station is full");

    a_bcast_tag: assert property (
        @(posedge clk) disable iff (rst)
        (alu_valid |-> alu_rob_id != rs_pkg::zero_rob) and
        (ls_valid |-> ls_rob_id != rs_pkg::zero_rob)
    ) else $error("result broadcast with zero tag");

    // flush frees every entry, so the issue path idles for two cycles
    a_rollback_bubble: assert property (
        @(posedge clk) disable iff (rst)
        (rollback || $past(rollback)) |=> issue_op == rs_pkg::op_nop
    ) else $error("issue after rollback");

endmodule

// File: src/alu_stage.sv
`timescale 1ns/1ps

module alu_stage (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rdy,
    input  logic                              rollback,

    input  logic [rs_pkg::op_width-1:0]       issue_op,
    input  logic [rs_pkg::data_width-1:0]     issue_v1,
    input  logic [rs_pkg::data_width-1:0]     issue_v2,
    input  logic [rs_pkg::data_width-1:0]     issue_pc,
    input  logic [rs_pkg::data_width-1:0]     issue_imm,
    input  logic [rs_pkg::rob_id_width-1:0]   issue_rob_id,

    output logic                              alu_valid,
    output logic [rs_pkg::rob_id_width-1:0]   alu_rob_id,
    output logic [rs_pkg::data_width-1:0]     alu_result
);

    logic [rs_pkg::data_width-1:0] result;
    logic [4:0]                    shamt;
    logic                          lt_s;
    logic                          lt_u;

    // RV32I uses only the low five bits of the shift amount
    assign shamt = issue_v2[4:0];
    assign lt_s  = $signed(issue_v1) < $signed(issue_v2);
    assign lt_u  = issue_v1 < issue_v2;

    always_comb begin
        case (issue_op)
            rs_pkg::op_add:   result = issue_v1 + issue_v2;
            rs_pkg::op_sub:   result = issue_v1 - issue_v2;
            rs_pkg::op_and:   result = issue_v1 & issue_v2;
            rs_pkg::op_or:    result = issue_v1 | issue_v2;
            rs_pkg::op_xor:   result = issue_v1 ^ issue_v2;
            rs_pkg::op_sll:   result = issue_v1 << shamt;
            rs_pkg::op_srl:   result = issue_v1 >> shamt;
            rs_pkg::op_sra:   result = $signed(issue_v1) >>> shamt;
            rs_pkg::op_slt:   result = {{(rs_pkg::data_width-1){1'b0}}, lt_s};
            rs_pkg::op_sltu:  result = {{(rs_pkg::data_width-1){1'b0}}, lt_u};
            rs_pkg::op_addi:  result = issue_v1 + issue_imm;
            rs_pkg::op_lui:   result = issue_imm;
            rs_pkg::op_auipc: result = issue_pc + issue_imm;
            // link address
            rs_pkg::op_jal:   result = issue_pc + 32'd4;
            default:          result = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst || rollback) begin
            alu_valid <= 1'b0;
        end else if (rdy) begin
            alu_valid <= (issue_op != rs_pkg::op_nop);
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issue_op != rs_pkg::op_nop) begin
            alu_rob_id <= issue_rob_id;
            alu_result <= result;
        end
    end

    // an issued entry always carries a real tag from dispatch
    a_result_tag: assert property (
        @(posedge clk) disable iff (rst) alu_valid |-> alu_rob_id != rs_pkg::zero_rob
    ) else $error("alu result with zero tag");

endmodule

// File: src/rs_exec_top.sv
`timescale 1ns/1ps

module rs_exec_top (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              rdy,
    input  logic                              rollback,

    input  logic                              ena,
    input  logic [rs_pkg::op_width-1:0]       op,
    input  logic [rs_pkg::data_width-1:0]     v1,
    input  logic [rs_pkg::data_width-1:0]     v2,
    input  logic [rs_pkg::rob_id_width-1:0]   q1,
    input  logic [rs_pkg::rob_id_width-1:0]   q2,
    input  logic [rs_pkg::data_width-1:0]     pc,
    input  logic [rs_pkg::data_width-1:0]     imm,
    input  logic [rs_pkg::rob_id_width-1:0]   rob_id,
    output logic                              full,

    input  logic                              ls_valid,
    input  logic [rs_pkg::rob_id_width-1:0]   ls_rob_id,
    input  logic [rs_pkg::data_width-1:0]     ls_result,

    output logic                              alu_valid,
    output logic [rs_pkg::rob_id_width-1:0]   alu_rob_id,
    output logic [rs_pkg::data_width-1:0]     alu_result
);

    // issue path, station to alu
    logic [rs_pkg::op_width-1:0]     issue_op;
    logic [rs_pkg::data_width-1:0]   issue_v1;
    logic [rs_pkg::data_width-1:0]   issue_v2;
    logic [rs_pkg::data_width-1:0]   issue_pc;
    logic [rs_pkg::data_width-1:0]   issue_imm;
    logic [rs_pkg::rob_id_width-1:0] issue_rob_id;

    res_station u_station (
        .clk(clk), .rst(rst), .rdy(rdy), .rollback(rollback),
        .ena(ena), .op(op), .v1(v1), .v2(v2), .q1(q1), .q2(q2),
        .pc(pc), .imm(imm), .rob_id(rob_id), .full(full),
        .issue_op(issue_op), .issue_v1(issue_v1), .issue_v2(issue_v2),
        .issue_pc(issue_pc), .issue_imm(issue_imm), .issue_rob_id(issue_rob_id),
        // alu result doubles as the wakeup bus
        .alu_valid(alu_valid), .alu_rob_id(alu_rob_id), .alu_result(alu_result),
        .ls_valid(ls_valid), .ls_rob_id(ls_rob_id), .ls_result(ls_result)
    );

    alu_stage u_alu (
        .clk(clk), .rst(rst), .rdy(rdy), .rollback(rollback),
        .issue_op(issue_op), .issue_v1(issue_v1), .issue_v2(issue_v2),
        .issue_pc(issue_pc), .issue_imm(issue_imm), .issue_rob_id(issue_rob_id),
        .alu_valid(alu_valid), .alu_rob_id(alu_rob_id), .alu_result(alu_result)
    );

endmodule

// File: verif/rs_exec_tb.sv
`timescale 1ns/1ps

module rs_exec_tb;

    localparam int max_recs   = 64;
    localparam int n_fields   = 12;
    localparam int clk_period = 4;

    logic                              clk;
    logic                              rst;
    logic                              rdy;
    logic                              rollback;
    logic                              ena;
    logic [rs_pkg::op_width-1:0]       op;
    logic [rs_pkg::data_width-1:0]     v1;
    logic [rs_pkg::data_width-1:0]     v2;
    logic [rs_pkg::rob_id_width-1:0]   q1;
    logic [rs_pkg::rob_id_width-1:0]   q2;
    logic [rs_pkg::data_width-1:0]     pc;
    logic [rs_pkg::data_width-1:0]     imm;
    logic [rs_pkg::rob_id_width-1:0]   rob_id;
    logic                              full;
    logic                              ls_valid;
    logic [rs_pkg::rob_id_width-1:0]   ls_rob_id;
    logic [rs_pkg::data_width-1:0]     ls_result;
    logic                              alu_valid;
    logic [rs_pkg::rob_id_width-1:0]   alu_rob_id;
    logic [rs_pkg::data_width-1:0]     alu_result;

    // one row per record: test kind op v1 v2 q1 q2 pc imm rob n expected
    logic [31:0] recs [max_recs][n_fields];
    int          n_recs;
    logic        loaded;

    // scoreboard indexed by rob id
    int          pend_cnt [16];
    logic [31:0] exp_val  [16];
    logic        seen     [16];

    int errors;
    int checks;
    int test_errors;
    int test_checks;
    int tests_done;

    // ls broadcast waiting to go out with the next dispatch
    logic        ls_share;
    logic [3:0]  share_tag;
    logic [31:0] share_val;

    rs_exec_top UUT (
        .clk(clk), .rst(rst), .rdy(rdy), .rollback(rollback),
        .ena(ena), .op(op), .v1(v1), .v2(v2), .q1(q1), .q2(q2),
        .pc(pc), .imm(imm), .rob_id(rob_id), .full(full),
        .ls_valid(ls_valid), .ls_rob_id(ls_rob_id), .ls_result(ls_result),
        .alu_valid(alu_valid), .alu_rob_id(alu_rob_id), .alu_result(alu_result)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        checks++;
        test_checks++;
        if (got !== exp) begin
            $display("CHECK FAILED %s: got %h expected %h", name, got, exp);
            errors++;
            test_errors++;
        end
    endtask

    task automatic note_error(input string msg);
        $display("ERROR: %s", msg);
        errors++;
        test_errors++;
    endtask

    task automatic load_records();
        int          fd;
        int          got;
        string       line;
        logic [31:0] f [n_fields];
        n_recs = 0;
        fd = $fopen("verif/rs_exec_input.txt", "r");
        if (fd == 0) begin
            note_error("cannot open verif/rs_exec_input.txt");
        end
        while (fd != 0 && !$feof(fd)) begin
            line = "";
            got = $fgets(line, fd);
            if (got > 0 && line.len() > 1 && line.getc(0) != "#") begin
                got = $sscanf(line, "%d %d %h %h %h %h %h %h %h %h %d %h",
                              f[0], f[1], f[2], f[3], f[4], f[5],
                              f[6], f[7], f[8], f[9], f[10], f[11]);
                if (got == n_fields && n_recs < max_recs) begin
                    for (int j = 0; j < n_fields; j++) begin
                        recs[n_recs][j] = f[j];
                    end
                    n_recs++;
                end else begin
                    note_error("malformed or surplus line in input file");
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
    endtask

    // copy k of a repeated dispatch takes the next rob id, wrapping within 1 to 14
    task automatic dispatch_op(input int r, input int k);
        logic [3:0] tag;
        tag = 4'(1 + (int'(recs[r][9]) - 1 + k) % 14);
        @(negedge clk);
        while (full) begin
            @(negedge clk);
        end
        @(posedge clk);
        ena    <= 1'b1;
        op     <= recs[r][2][3:0];
        v1     <= recs[r][3];
        v2     <= recs[r][4];
        q1     <= recs[r][5][3:0];
        q2     <= recs[r][6][3:0];
        pc     <= recs[r][7];
        imm    <= recs[r][8];
        rob_id <= tag;
        if (ls_share) begin
            ls_valid  <= 1'b1;
            ls_rob_id <= share_tag;
            ls_result <= share_val;
            ls_share  = 1'b0;
        end
        if (recs[r][1] == 0) begin
            pend_cnt[tag]++;
            exp_val[tag] = recs[r][11];
            seen[tag]    = 1'b0;
        end
        @(posedge clk);
        ena      <= 1'b0;
        ls_valid <= 1'b0;
    endtask

    task automatic finish_test(input int num);
        logic waiting;
        waiting = 1'b1;
        while (waiting) begin
            @(negedge clk);
            waiting = 1'b0;
            for (int t = 0; t < 16; t++) begin
                if (pend_cnt[t] > 0) begin
                    waiting = 1'b1;
                end
            end
        end
        // a few more cycles so stray or repeated results still show up
        repeat (8) @(negedge clk);
        $display("test %0d finished: %0d checks, %0d errors", num, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
        tests_done++;
    endtask

    // results count only in cycles where the station consumes them
    always @(negedge clk) begin
        if (!rst && rdy && alu_valid) begin
            if (pend_cnt[alu_rob_id] > 0) begin
                check_value("alu_result", alu_result, exp_val[alu_rob_id]);
                pend_cnt[alu_rob_id]--;
                seen[alu_rob_id] = 1'b1;
            end else if (seen[alu_rob_id]) begin
                note_error($sformatf("duplicate result for rob id %0d", alu_rob_id));
            end else begin
                note_error($sformatf("unexpected result for rob id %0d", alu_rob_id));
            end
        end
    end

    initial begin
        wait (loaded);
        repeat (n_recs * 40 + 200) @(posedge clk);
        $display("timeout: run did not end within %0d cycles", n_recs * 40 + 200);
        $display("SIMULATION FAILED");
        $finish;
    end

    initial begin
        int kind;
        rst = 1'b1;
        rdy = 1'b1;
        rollback = 1'b0;
        ena = 1'b0;
        op = rs_pkg::op_nop;
        v1 = '0;
        v2 = '0;
        q1 = '0;
        q2 = '0;
        pc = '0;
        imm = '0;
        rob_id = '0;
        ls_valid = 1'b0;
        ls_rob_id = '0;
        ls_result = '0;
        ls_share = 1'b0;
        share_tag = '0;
        share_val = '0;
        errors = 0;
        checks = 0;
        test_errors = 0;
        test_checks = 0;
        tests_done = 0;
        for (int t = 0; t < 16; t++) begin
            pend_cnt[t] = 0;
            exp_val[t]  = '0;
            seen[t]     = 1'b0;
        end
        loaded = 1'b0;
        load_records();
        loaded = 1'b1;

        repeat (5) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < n_recs; i++) begin
            if (i > 0 && recs[i][0] != recs[i-1][0]) begin
                finish_test(int'(recs[i-1][0]));
            end
            kind = int'(recs[i][1]);
            case (kind)
                0, 1: begin
                    for (int k = 0; k < int'(recs[i][10]); k++) begin
                        dispatch_op(i, k);
                    end
                end
                2: begin
                    if (recs[i][10] != 0) begin
                        ls_share  = 1'b1;
                        share_tag = recs[i][9][3:0];
                        share_val = recs[i][3];
                    end else begin
                        @(posedge clk);
                        ls_valid  <= 1'b1;
                        ls_rob_id <= recs[i][9][3:0];
                        ls_result <= recs[i][3];
                        @(posedge clk);
                        ls_valid  <= 1'b0;
                    end
                end
                3: begin
                    @(posedge clk);
                    rollback <= 1'b1;
                    @(posedge clk);
                    rollback <= 1'b0;
                end
                4: begin
                    @(posedge clk);
                    rdy <= 1'b0;
                    repeat (recs[i][10]) @(posedge clk);
                    rdy <= 1'b1;
                end
                5: repeat (recs[i][10]) @(posedge clk);
                6: begin
                    @(negedge clk);
                    check_value("full", {31'b0, full}, recs[i][10]);
                end
                default: note_error($sformatf("unknown record kind %0d", kind));
            endcase
        end
        if (n_recs > 0) begin
            finish_test(int'(recs[n_recs-1][0]));
        end

        $display("%0d tests, %0d checks, %0d errors", tests_done, checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: verif/rs_exec_input.txt
# columns: test kind op v1 v2 q1 q2 pc imm rob n expected (test, kind and n decimal)
# kind: 0 dispatch with result, 1 dispatch lost to rollback, 2 ls bus (tag in rob, value in v1,
# n=1 shares the next dispatch's cycle), 3 rollback, 4 rdy low n cycles, 5 idle, 6 full == n
# n copies of a dispatch take rob ids from rob upward, wrapping within 1 to 14
1 0 1 00000005 00000003 0 0 0 0 1 1 00000008
1 0 2 00000005 00000007 0 0 0 0 2 1 fffffffe
1 0 3 f0f0f0f0 ff00ff00 0 0 0 0 3 1 f000f000
1 0 4 f0f0f0f0 0f0f0000 0 0 0 0 4 1 fffff0f0
1 0 5 ffff0000 0ff00ff0 0 0 0 0 5 1 f00f0ff0
1 0 6 00000001 00000024 0 0 0 0 6 1 00000010
1 0 7 80000000 0000001f 0 0 0 0 7 1 00000001
1 0 8 80000000 00000004 0 0 0 0 8 1 f8000000
1 0 9 ffffffff 00000001 0 0 0 0 9 1 00000001
1 0 a ffffffff 00000001 0 0 0 0 a 1 00000000
1 0 b 00000010 0 0 0 0 fffffff0 b 1 00000000
1 0 c 0 0 0 0 0 12345000 c 1 12345000
1 0 d 0 0 0 0 00001000 00000200 d 1 00001200
1 0 e 0 0 0 0 00002000 0 e 1 00002004
2 0 1 00000001 00000002 0 0 0 0 1 1 00000003
2 0 b 0 0 1 0 0 00000010 2 1 00000013
2 0 2 00000100 0 0 2 0 0 3 1 000000ed
3 0 1 0 00000005 f 0 0 0 4 1 00000105
3 2 0 00000100 0 0 0 0 0 f 1 0
3 0 3 0000ffff 0 0 f 0 0 5 1 00000100
4 0 b 0 0 f 0 0 00000010 1 16 00000210
4 6 0 0 0 0 0 0 0 0 1 0
4 2 0 00000200 0 0 0 0 0 f 0 0
4 0 b 00000200 0 0 0 0 00000010 5 1 00000210
5 1 1 00000001 0 0 f 0 0 1 2 0
5 3 0 0 0 0 0 0 0 0 0 0
5 2 0 00000055 0 0 0 0 0 f 0 0
5 5 0 0 0 0 0 0 0 0 4 0
5 0 1 00000001 00000001 0 0 0 0 3 1 00000002
6 0 1 00000010 00000020 0 0 0 0 1 1 00000030
6 0 5 000000ff 0000000f 0 0 0 0 2 1 000000f0
6 4 0 0 0 0 0 0 0 0 6 0
6 0 4 0 00000100 2 0 0 0 3 1 000001f0

// File: rs_exec.f
src/rs_pkg.sv
src/res_station.sv
src/alu_stage.sv
src/rs_exec_top.sv
verif/rs_exec_tb.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it, then scan the log for the fail message
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f rs_exec.f --top-module rs_exec_tb \
    -o rs_exec_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }

./obj_dir/rs_exec_sim > sim.log 2>&1 || { cat sim.log; echo "simulator exited with error"; exit 1; }
cat sim.log

grep -q "SIMULATION FAILED" sim.log && { echo "run failed"; exit 1; }
grep -q "SIMULATION PASSED" sim.log || { echo "run ended without a verdict"; exit 1; }
exit 0
